// File: src/ifu_macros.svh
// Widths assume a word-aligned 32-bit ISA and a 16-bit byte address space.
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// Byte address width.
`define IFU_AW 16

// Instruction word width.
`define IFU_IW 32

// Word PC width, byte address minus the two offset bits.
`define IFU_PCW (`IFU_AW - 2)

// ROM depth in words, indexed by the low PC bits so fetches wrap.
`define IFU_ROM_WORDS 256

// Width of the post-reset warm-up counter.
`define IFU_WARMUP 3

`endif

// File: src/ifu_isa_pkg.sv
// Only the three PC-relative jump opcodes are known here and every other opcode is a plain word.
`default_nettype none

`include "ifu_macros.svh"

package ifu_isa_pkg;

   // Opcode lives in the low six instruction bits.
   localparam int OPC_W = 6;

   // Relative offset starts right above the opcode.
   localparam int OFFS_LSB = OPC_W;

   // Offset field width before truncation to the PC width.
   localparam int OFFS_W = `IFU_IW - OFFS_LSB;

   typedef logic [OPC_W-1:0] opcode_t;

   // Unconditional relative jump.
   localparam opcode_t OP_JMP_REL = 6'd1;

   // Relative jump that also writes the link register.
   localparam opcode_t OP_JMP_LINK = 6'd2;

   // Relative branch, taken when the condition flag is set.
   localparam opcode_t OP_BCC = 6'd3;

   // Predecode result for one instruction word.
   typedef struct packed {
      // Word is one of the relative jumps.
      logic                  op_jmprel;
      // Word is the linked jump.
      logic                  jmprel_link;
      // Fetch follows the jump.
      logic                  taken;
      // Signed word offset, already cut to PC width.
      logic [`IFU_PCW-1:0]   offset;
   } predecode_t;

endpackage

`default_nettype wire

// File: src/ifu_bus_pkg.sv
// PCs here are word indices, so byte addresses are formed by the user of these structs.
`default_nettype none

`include "ifu_macros.svh"

package ifu_bus_pkg;

   // ROM response payload.
   typedef struct packed {
      // Fetched instruction word.
      logic [`IFU_IW-1:0]    insn;
      // Word PC the instruction came from.
      logic [`IFU_PCW-1:0]   pc;
   } fetch_rsp_t;

   // Fetch output payload toward the decoder.
   typedef struct packed {
      logic [`IFU_IW-1:0]    insn;
      logic [`IFU_PCW-1:0]   pc;
      // Predecoded jump flags, zero while the output is idle.
      logic                  op_jmprel;
      logic                  jmprel_link;
   } fetch_out_t;

endpackage

`default_nettype wire

// File: src/fetch_pipe_buf.sv
// Single entry only, so full throughput needs the consumer to drain in the same cycle.
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module fetch_pipe_buf #(
   parameter type payload_t = logic
) (
   input  wire       clk,
   input  wire       reset,
   input  wire       in_valid,
   output logic      in_ready,
   input  wire       payload_t in_data,
   output logic      out_valid,
   input  wire       out_ready,
   output payload_t  out_data,
   output logic      accept
);

   logic       valid_q;
   payload_t   data_q;

   // Free slot, or the held entry leaves this cycle.
   assign in_ready = ~valid_q | out_ready;

   // Load strobe, also used by the parent for side effects.
   assign accept = in_valid & in_ready;

   // Occupancy.
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (accept) begin
         valid_q <= 1'b1;
      end else if (out_ready) begin
         valid_q <= 1'b0;
      end
   end

   // Payload holds while stalled.
   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= in_data;
      end
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

endmodule

`default_nettype wire

// File: src/branch_predecoder.sv
// Purely combinational, and an offset wider than the PC is truncated so jump targets wrap.
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module branch_predecoder (
   input  wire  [`IFU_IW-1:0]          insn,
   input  wire                         cond_flag,
   output ifu_isa_pkg::predecode_t     pre
);

   localparam int PCW = `IFU_PCW;

   ifu_isa_pkg::opcode_t               opcode;
   logic [ifu_isa_pkg::OFFS_W-1:0]     offs_field;
   logic                               is_jmp;
   logic                               is_link;
   logic                               is_bcc;

   // Field extraction.
   assign opcode     = insn[ifu_isa_pkg::OPC_W-1:0];
   assign offs_field = insn[`IFU_IW-1:ifu_isa_pkg::OFFS_LSB];

   // Opcode match against the three jump kinds.
   assign is_jmp  = (opcode == ifu_isa_pkg::OP_JMP_REL);
   assign is_link = (opcode == ifu_isa_pkg::OP_JMP_LINK);
   assign is_bcc  = (opcode == ifu_isa_pkg::OP_BCC);

   always_comb begin
      pre.op_jmprel   = is_jmp | is_link | is_bcc;
      pre.jmprel_link = is_link;
      // Conditional branch only follows a set flag.
      pre.taken       = is_jmp | is_link | (is_bcc & cond_flag);
      // Sign extend or truncate the field to PC width.
      pre.offset      = PCW'($signed(offs_field));
   end

endmodule

`default_nettype wire

// File: src/inst_rom.sv
// Contents come from program.hex at elaboration and the index wraps at the ROM depth.
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module inst_rom (
   input  wire                         clk,
   input  wire                         reset,
   input  wire  [`IFU_AW-1:0]          fetch_addr,
   output logic                        rsp_valid,
   input  wire                         rsp_ready,
   output ifu_bus_pkg::fetch_rsp_t     rsp
);

   localparam int ROM_AW = $clog2(`IFU_ROM_WORDS);

   logic [`IFU_IW-1:0]        mem [`IFU_ROM_WORDS];
   logic                      start_q;
   logic                      load;
   logic                      loaded;
   logic [`IFU_PCW-1:0]       ld_pc;
   ifu_bus_pkg::fetch_rsp_t   ld_rsp;

   initial begin
      $readmemh("program.hex", mem);
   end

   // First fetch after reset, cleared once word 0 is in.
   always_ff @(posedge clk) begin
      if (reset) begin
         start_q <= 1'b1;
      end else if (loaded) begin
         start_q <= 1'b0;
      end
   end

   // Load on start or whenever the held response is taken.
   assign load  = start_q | (rsp_valid & rsp_ready);
   assign ld_pc = start_q ? '0 : fetch_addr[`IFU_AW-1:2];

   always_comb begin
      ld_rsp.insn = mem[ld_pc[ROM_AW-1:0]];
      ld_rsp.pc   = ld_pc;
   end

   // Response register.
   fetch_pipe_buf #(
      .payload_t (ifu_bus_pkg::fetch_rsp_t)
   ) pipebuf_rsp (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (load),
      .in_ready  (),
      .in_data   (ld_rsp),
      .out_valid (rsp_valid),
      .out_ready (rsp_ready),
      .out_data  (rsp),
      .accept    (loaded)
   );

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
// Words already buffered when a redirect arrives are still delivered and must be killed downstream.
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module fetch_unit (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            rsp_valid,
   output logic                           rsp_ready,
   input  wire  ifu_bus_pkg::fetch_rsp_t  rsp,
   output logic [`IFU_AW-1:0]             fetch_addr,
   input  wire                            redirect,
   input  wire  [`IFU_PCW-1:0]            redirect_pc,
   input  wire                            cond_flag,
   output logic                           out_valid,
   input  wire                            out_ready,
   output ifu_bus_pkg::fetch_out_t        out
);

   ifu_isa_pkg::predecode_t   pre;
   logic [`IFU_WARMUP-1:0]    warm_cnt;
   logic                      warm_done;
   logic                      buf_ready;
   logic                      rsp_xfer;
   logic                      redir_pend;
   logic [`IFU_PCW-1:0]       redir_pc_q;
   logic [`IFU_PCW-1:0]       next_pc;
   ifu_bus_pkg::fetch_out_t   out_d;
   ifu_bus_pkg::fetch_out_t   out_q;

   // Predecode the word being offered by memory.
   branch_predecoder predecoder (
      .insn      (rsp.insn),
      .cond_flag (cond_flag),
      .pre       (pre)
   );

   // Warm-up counter, stops once bit 1 is set.
   always_ff @(posedge clk) begin
      if (reset) begin
         warm_cnt <= '0;
      end else if (!warm_done) begin
         warm_cnt <= warm_cnt + 1'b1;
      end
   end

   assign warm_done = warm_cnt[1];

   // Accept from memory only after warm-up and with room downstream.
   assign rsp_ready = buf_ready & warm_done;

   // Pending far redirect, newest one wins.
   always_ff @(posedge clk) begin
      if (reset) begin
         redir_pend <= 1'b0;
      end else if (redirect && !rsp_xfer) begin
         redir_pend <= 1'b1;
      end else if (rsp_xfer) begin
         redir_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (redirect && !rsp_xfer) begin
         redir_pc_q <= redirect_pc;
      end
   end

   // Next word PC by priority.
   always_comb begin
      if (redirect) begin
         next_pc = redirect_pc;
      end else if (redir_pend) begin
         next_pc = redir_pc_q;
      end else if (pre.taken) begin
         next_pc = rsp.pc + pre.offset;
      end else begin
         next_pc = rsp.pc + 1'b1;
      end
   end

   // Word aligned byte address.
   assign fetch_addr = {next_pc, 2'b00};

   // Output payload.
   always_comb begin
      out_d.insn        = rsp.insn;
      out_d.pc          = rsp.pc;
      out_d.op_jmprel   = pre.op_jmprel;
      out_d.jmprel_link = pre.jmprel_link;
   end

   fetch_pipe_buf #(
      .payload_t (ifu_bus_pkg::fetch_out_t)
   ) pipebuf_out (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (rsp_valid & warm_done),
      .in_ready  (buf_ready),
      .in_data   (out_d),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_q),
      .accept    (rsp_xfer)
   );

   // Flags read as zero while idle.
   always_comb begin
      out             = out_q;
      out.op_jmprel   = out_q.op_jmprel & out_valid;
      out.jmprel_link = out_q.jmprel_link & out_valid;
   end

endmodule

`default_nettype wire

// File: src/fetch_top.sv
// Start-up latency to the first output varies with warm-up, so wait for out_valid.
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module fetch_top (
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         redirect,
   input  wire  [`IFU_PCW-1:0]         redirect_pc,
   input  wire                         cond_flag,
   output logic                        out_valid,
   input  wire                         out_ready,
   output ifu_bus_pkg::fetch_out_t     out
);

   // Memory response channel.
   logic                      rsp_valid;
   logic                      rsp_ready;
   ifu_bus_pkg::fetch_rsp_t   rsp;
   logic [`IFU_AW-1:0]        fetch_addr;

   // Instruction memory.
   inst_rom rom (
      .clk        (clk),
      .reset      (reset),
      .fetch_addr (fetch_addr),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp        (rsp)
   );

   // Fetch stage.
   fetch_unit ifu (
      .clk         (clk),
      .reset       (reset),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp         (rsp),
      .fetch_addr  (fetch_addr),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .cond_flag   (cond_flag),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out         (out)
   );

endmodule

`default_nettype wire

// File: tests/tb_fetch_top.sv
// Needs program.hex in the working directory, and every walked PC must stay inside its loaded words.
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module tb_fetch_top;

   localparam int RESET_CYCLES    = 10;
   localparam int CYCLES_PER_WORD = 40;
   localparam int NUM_TESTS       = 7;

   // Jump opcodes of the ISA.
   localparam logic [5:0] JMP_REL_OP  = 6'd1;
   localparam logic [5:0] JMP_LINK_OP = 6'd2;
   localparam logic [5:0] BCC_OP      = 6'd3;

   // One row of the test table.
   typedef struct packed {
      logic                  cond;
      logic [1:0]            density;
      logic [15:0]           count;
      logic                  has_redir;
      logic [15:0]           redir_idx;
      logic [`IFU_PCW-1:0]   redir_pc;
   } test_row_t;

   // cond, stall density, words, redirect on, redirect index, target.
   localparam test_row_t TESTS [NUM_TESTS] = '{
      '{1'b0, 2'd0, 16'd24, 1'b0, 16'd0, 14'd0},
      '{1'b1, 2'd0, 16'd24, 1'b0, 16'd0, 14'd0},
      '{1'b0, 2'd2, 16'd40, 1'b0, 16'd0, 14'd0},
      '{1'b1, 2'd3, 16'd40, 1'b0, 16'd0, 14'd0},
      '{1'b0, 2'd2, 16'd30, 1'b1, 16'd6, 14'd24},
      '{1'b1, 2'd1, 16'd24, 1'b1, 16'd2, 14'd5},
      '{1'b0, 2'd3, 16'd20, 1'b1, 16'd0, 14'd26}
   };

   logic                      clk;
   logic                      reset;
   logic                      redirect;
   logic [`IFU_PCW-1:0]       redirect_pc;
   logic                      cond_flag;
   logic                      out_valid;
   logic                      out_ready;
   ifu_bus_pkg::fetch_out_t   out;

   // Reference copy of the program.
   logic [`IFU_IW-1:0]        rom_image [`IFU_ROM_WORDS];
   logic [31:0]               lfsr_state;
   int                        error_count;
   int                        check_count;
   int                        failed_tests;

   fetch_top u_dut (
      .clk         (clk),
      .reset       (reset),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .cond_flag   (cond_flag),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out         (out)
   );

   // 20 ns clock.
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR, taps 32 22 2 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // Two fresh bits, stall chance is density out of four.
   task automatic draw_stall(input logic [1:0] density, output logic stall);
      logic [1:0] pick;
      lfsr_state = lfsr_next(lfsr_state);
      pick[0]    = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      pick[1]    = lfsr_state[0];
      stall      = (pick < density);
   endtask

   // Next word PC of the reference walk.
   function automatic logic [`IFU_PCW-1:0] model_next_pc(input logic [`IFU_PCW-1:0] pc,
                                                         input logic [`IFU_IW-1:0]  insn,
                                                         input logic                cond);
      logic [5:0]            opcode;
      logic [`IFU_PCW-1:0]   offset;
      logic                  follow;
      opcode = insn[5:0];
      // Sign extension then truncation keeps just the low field bits.
      offset = insn[`IFU_PCW+5:6];
      follow = (opcode == JMP_REL_OP) || (opcode == JMP_LINK_OP) ||
               ((opcode == BCC_OP) && cond);
      if (follow) begin
         return pc + offset;
      end
      return pc + 1'b1;
   endfunction

   function automatic int total_words();
      int sum;
      sum = 0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         sum += TESTS[i].count;
      end
      return sum;
   endfunction

   task automatic report_mismatch(input int test, input int word, input string what,
                                  input logic [31:0] got, input logic [31:0] exp);
      error_count++;
      $display("[ERROR] t=%0t test %0d word %0d: %s is %h, expected %h",
               $time, test, word, what, got, exp);
   endtask

   // Reset, stream the row's words and compare each transfer.
   task automatic run_test(input int idx);
      test_row_t             row;
      logic [`IFU_PCW-1:0]   exp_pc;
      logic [`IFU_PCW-1:0]   next_pc;
      logic [`IFU_IW-1:0]    exp_insn;
      logic                  exp_jmp;
      logic                  exp_link;
      logic                  stall;
      int                    seen;
      int                    redir_left;
      int                    errors_before;
      row           = TESTS[idx];
      errors_before = error_count;
      @(posedge clk);
      reset     <= 1'b1;
      redirect  <= 1'b0;
      out_ready <= 1'b0;
      cond_flag <= row.cond;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      draw_stall(row.density, stall);
      out_ready <= ~stall;
      exp_pc     = '0;
      seen       = 0;
      redir_left = 0;
      while (seen < row.count) begin
         @(posedge clk);
         redirect <= 1'b0;
         // Idle output keeps its flags low.
         if (!out_valid && (out.op_jmprel || out.jmprel_link)) begin
            report_mismatch(idx, seen, "idle flags", {out.op_jmprel, out.jmprel_link}, 0);
         end
         if (out_valid && out_ready) begin
            exp_insn = rom_image[exp_pc % `IFU_ROM_WORDS];
            exp_jmp  = (exp_insn[5:0] == JMP_REL_OP) || (exp_insn[5:0] == JMP_LINK_OP) ||
                       (exp_insn[5:0] == BCC_OP);
            exp_link = (exp_insn[5:0] == JMP_LINK_OP);
            check_count++;
            if (out.pc !== exp_pc) begin
               report_mismatch(idx, seen, "pc", out.pc, exp_pc);
            end
            if (out.insn !== exp_insn) begin
               report_mismatch(idx, seen, "insn", out.insn, exp_insn);
            end
            if (out.op_jmprel !== exp_jmp) begin
               report_mismatch(idx, seen, "op_jmprel", out.op_jmprel, exp_jmp);
            end
            if (out.jmprel_link !== exp_link) begin
               report_mismatch(idx, seen, "jmprel_link", out.jmprel_link, exp_link);
            end
            next_pc = model_next_pc(exp_pc, exp_insn, row.cond);
            // Buffered word, then the word taken with the redirect, then the target.
            if (redir_left > 0) begin
               redir_left--;
               if (redir_left == 0) begin
                  next_pc = row.redir_pc;
               end
            end
            if (row.has_redir && (seen == row.redir_idx)) begin
               redirect    <= 1'b1;
               redirect_pc <= row.redir_pc;
               redir_left  = 2;
            end
            exp_pc = next_pc;
            seen++;
         end
         draw_stall(row.density, stall);
         out_ready <= ~stall;
      end
      if (error_count == errors_before) begin
         $display("test %0d passed: %0d words, cond %0d, density %0d, redirect %0d",
                  idx, row.count, row.cond, row.density, row.has_redir);
      end else begin
         failed_tests++;
         $display("test %0d failed with %0d errors", idx, error_count - errors_before);
      end
   endtask

   initial begin : stimulus
      reset        = 1'b1;
      redirect     = 1'b0;
      redirect_pc  = '0;
      cond_flag    = 1'b0;
      out_ready    = 1'b0;
      error_count  = 0;
      check_count  = 0;
      failed_tests = 0;
      lfsr_state   = 32'h287f03e7;
      $readmemh("program.hex", rom_image);
      for (int i = 0; i < NUM_TESTS; i++) begin
         run_test(i);
      end
      $display("tests %0d, failed %0d, words checked %0d, errors %0d",
               NUM_TESTS, failed_tests, check_count, error_count);
      if ((error_count == 0) && (check_count > 0)) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Hang guard, sized by the table.
   initial begin : watchdog
      int limit;
      limit = total_words() * CYCLES_PER_WORD;
      repeat (limit) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: program.hex
// One 32-bit word per line: offset in bits 31..6, opcode in bits 5..0
0000a004
11110010
2222202a
3333303f
00000101
deadbe80
deadbec0
deadbe40
55555504
00000143
0a0a0a05
0b0b0b06
00000182
0d0d0d07
0e0e0e08
ffffff42
10101009
1111110a
1212120b
1313130c
fffffd43
1515150d
1616160e
fffffa41
18181811
19191912
fffffd81
1b1b1b13
1c1c1c14
1d1d1d15
1e1e1e16
1f1f1f17

// File: all.f
+incdir+src
src/ifu_isa_pkg.sv
src/ifu_bus_pkg.sv
src/fetch_pipe_buf.sv
src/branch_predecoder.sv
src/inst_rom.sv
src/fetch_unit.sv
src/fetch_top.sv
tests/tb_fetch_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_fetch_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Test FAILED
PASS_MSG  := Test OK

SOURCES := $(filter-out +incdir%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) program.hex
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No pass message in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
